//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t im_data,
    input  cpu_pkg::word_t dm_rdata,
    output cpu_pkg::word_t im_addr,
    output logic           dm_en,
    output logic           dm_we,
    output cpu_pkg::word_t dm_addr,
    output cpu_pkg::word_t dm_wdata
);

    // fetch to decode
    cpu_pkg::word_t id_pc, id_insn;

    // decode to execute
    cpu_pkg::word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    cpu_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
    cpu_pkg::alu_op_t   ex_alu_op;
    logic ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic ex_branch, ex_branch_ne;

    // execute to mem
    cpu_pkg::word_t     mem_alu_result, mem_store_data, mem_fwd_data;
    cpu_pkg::reg_addr_t mem_rd;
    logic mem_reg_write, mem_read, mem_write;

    // writeback bus and pipeline control
    logic               wb_we;
    cpu_pkg::reg_addr_t wb_rd;
    cpu_pkg::word_t     wb_data;
    logic               stall, redirect;
    cpu_pkg::word_t     redirect_pc;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk (clk), .rst (rst), .stall (stall), .redirect (redirect),
        .redirect_pc (redirect_pc), .im_data (im_data), .im_addr (im_addr),
        .id_pc (id_pc), .id_insn (id_insn)
    );

    decode_stage u_decode (
        .clk (clk), .rst (rst), .id_pc (id_pc), .id_insn (id_insn),
        .redirect (redirect), .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data),
        .ex_pc (ex_pc), .ex_rs1_data (ex_rs1_data), .ex_rs2_data (ex_rs2_data),
        .ex_imm (ex_imm), .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd),
        .ex_alu_op (ex_alu_op), .ex_use_imm (ex_use_imm), .ex_reg_write (ex_reg_write),
        .ex_mem_read (ex_mem_read), .ex_mem_write (ex_mem_write),
        .ex_branch (ex_branch), .ex_branch_ne (ex_branch_ne), .stall (stall)
    );

    execute_stage u_execute (
        .clk (clk), .rst (rst), .ex_pc (ex_pc), .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data), .ex_imm (ex_imm), .ex_rs1 (ex_rs1),
        .ex_rs2 (ex_rs2), .ex_rd (ex_rd), .ex_alu_op (ex_alu_op),
        .ex_use_imm (ex_use_imm), .ex_reg_write (ex_reg_write),
        .ex_mem_read (ex_mem_read), .ex_mem_write (ex_mem_write),
        .ex_branch (ex_branch), .ex_branch_ne (ex_branch_ne),
        .mem_fwd_data (mem_fwd_data), .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .mem_alu_result (mem_alu_result), .mem_store_data (mem_store_data),
        .mem_rd (mem_rd), .mem_reg_write (mem_reg_write), .mem_read (mem_read),
        .mem_write (mem_write)
    );

    mem_stage u_mem (
        .clk (clk), .rst (rst), .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data), .mem_rd (mem_rd),
        .mem_reg_write (mem_reg_write), .mem_read (mem_read), .mem_write (mem_write),
        .dm_rdata (dm_rdata), .dm_en (dm_en), .dm_we (dm_we), .dm_addr (dm_addr),
        .dm_wdata (dm_wdata), .mem_fwd_data (mem_fwd_data),
        .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data)
    );

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // ----------------------------------------
    // major opcodes kept by this core
    // ----------------------------------------
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // addi x0, x0, 0
    localparam word_t NOP_INSN = 32'h0000_0013;

    // add also forms the lw and sw address
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::word_t      id_pc,
    input  cpu_pkg::word_t      id_insn,
    input  logic                redirect,
    input  logic                wb_we,
    input  cpu_pkg::reg_addr_t  wb_rd,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::word_t      ex_pc,
    output cpu_pkg::word_t      ex_rs1_data,
    output cpu_pkg::word_t      ex_rs2_data,
    output cpu_pkg::word_t      ex_imm,
    output cpu_pkg::reg_addr_t  ex_rs1,
    output cpu_pkg::reg_addr_t  ex_rs2,
    output cpu_pkg::reg_addr_t  ex_rd,
    output cpu_pkg::alu_op_t    ex_alu_op,
    output logic                ex_use_imm,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_branch,
    output logic                ex_branch_ne,
    output logic                stall
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    logic [2:0]         funct3;
    logic               funct7_5;
    cpu_pkg::word_t     imm_i;
    cpu_pkg::word_t     imm_s;
    cpu_pkg::word_t     imm_b;
    cpu_pkg::word_t     imm;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;
    cpu_pkg::alu_op_t   alu_op;
    logic use_imm, reg_write, mem_read, mem_write, branch;
    logic uses_rs1, uses_rs2;
    logic bubble;

    assign opcode   = id_insn[6:0];
    assign rd       = id_insn[11:7];
    assign funct3   = id_insn[14:12];
    assign rs1      = id_insn[19:15];
    assign rs2      = id_insn[24:20];
    assign funct7_5 = id_insn[30];

    assign imm_i = {{20{id_insn[31]}}, id_insn[31:20]};
    assign imm_s = {{20{id_insn[31]}}, id_insn[31:25], id_insn[11:7]};
    assign imm_b = {{19{id_insn[31]}}, id_insn[31], id_insn[7], id_insn[30:25],
                    id_insn[11:8], 1'b0};

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .we       (wb_we),
        .rd_addr  (wb_rd),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ----------------------------------------
    // control decode with unknown encodings falling out as nops
    // ----------------------------------------
    always_comb begin
        alu_op    = cpu_pkg::ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7_5 ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b010:  alu_op = cpu_pkg::ALU_SLT;
                    3'b100:  alu_op = cpu_pkg::ALU_XOR;
                    3'b110:  alu_op = cpu_pkg::ALU_OR;
                    3'b111:  alu_op = cpu_pkg::ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            // addi only
            cpu_pkg::OPC_OP_IMM: begin
                uses_rs1  = 1'b1;
                use_imm   = 1'b1;
                reg_write = (funct3 == 3'b000);
            end
            cpu_pkg::OPC_LOAD: begin
                uses_rs1  = 1'b1;
                use_imm   = 1'b1;
                mem_read  = (funct3 == 3'b010);
                reg_write = (funct3 == 3'b010);
            end
            cpu_pkg::OPC_STORE: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_s;
                mem_write = (funct3 == 3'b010);
            end
            // funct3[0] picks bne over beq
            cpu_pkg::OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                branch   = (funct3[2:1] == 2'b00);
            end
            default: ;
        endcase
    end

    // load in EX whose result is needed here next cycle
    assign stall = ex_mem_read && ex_rd != '0 && !redirect &&
                   ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

    assign bubble = stall || redirect;

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
        end else begin
            ex_reg_write <= reg_write && !bubble;
            ex_mem_read  <= mem_read && !bubble;
            ex_mem_write <= mem_write && !bubble;
            ex_branch    <= branch && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rd        <= rd;
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_branch_ne <= funct3[0];
    end

    assert property (@(posedge clk) disable iff (rst) !(ex_mem_read && ex_mem_write))
        else $error("load and store issued together");

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::word_t      ex_pc,
    input  cpu_pkg::word_t      ex_rs1_data,
    input  cpu_pkg::word_t      ex_rs2_data,
    input  cpu_pkg::word_t      ex_imm,
    input  cpu_pkg::reg_addr_t  ex_rs1,
    input  cpu_pkg::reg_addr_t  ex_rs2,
    input  cpu_pkg::reg_addr_t  ex_rd,
    input  cpu_pkg::alu_op_t    ex_alu_op,
    input  logic                ex_use_imm,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_branch,
    input  logic                ex_branch_ne,
    input  cpu_pkg::word_t      mem_fwd_data,
    input  logic                wb_we,
    input  cpu_pkg::reg_addr_t  wb_rd,
    input  cpu_pkg::word_t      wb_data,
    output logic                redirect,
    output cpu_pkg::word_t      redirect_pc,
    output cpu_pkg::word_t      mem_alu_result,
    output cpu_pkg::word_t      mem_store_data,
    output cpu_pkg::reg_addr_t  mem_rd,
    output logic                mem_reg_write,
    output logic                mem_read,
    output logic                mem_write
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_result;
    logic           equal;

    // MEM result first, then the writeback bus, then the ID/EX copy
    function automatic cpu_pkg::word_t fwd_sel(cpu_pkg::reg_addr_t rs, cpu_pkg::word_t rf_val);
        if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
            return mem_fwd_data;
        end else if (wb_we && wb_rd != '0 && wb_rd == rs) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign op_a  = fwd_sel(ex_rs1, ex_rs1_data);
    assign op_b  = fwd_sel(ex_rs2, ex_rs2_data);
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (ex_alu_op)
            cpu_pkg::ALU_SUB: alu_result = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_result = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | alu_b;
            cpu_pkg::ALU_XOR: alu_result = op_a ^ alu_b;
            cpu_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
            default:          alu_result = op_a + alu_b;
        endcase
    end

    // a taken branch here kills the two younger instructions
    assign equal       = (op_a == op_b);
    assign redirect    = ex_branch && (ex_branch_ne ? !equal : equal);
    assign redirect_pc = ex_pc + ex_imm;

    // ----------------------------------------
    // EX/MEM register
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_result;
        mem_store_data <= op_b;
        mem_rd         <= ex_rd;
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t im_data,
    output cpu_pkg::word_t im_addr,
    output cpu_pkg::word_t id_pc,
    output cpu_pkg::word_t id_insn
);

    cpu_pkg::word_t pc;

    // redirect wins over stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // instruction memory answers in the same cycle
    assign im_addr = pc;

    // ----------------------------------------
    // IF/ID register
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_insn <= cpu_pkg::NOP_INSN;
        end else if (redirect) begin
            id_insn <= cpu_pkg::NOP_INSN;
        end else if (!stall) begin
            id_insn <= im_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    // load-use stall comes from decode, redirect from execute
    assert property (@(posedge clk) disable iff (rst) !(stall && redirect))
        else $error("stall and redirect high in the same cycle");

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::word_t      mem_alu_result,
    input  cpu_pkg::word_t      mem_store_data,
    input  cpu_pkg::reg_addr_t  mem_rd,
    input  logic                mem_reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  cpu_pkg::word_t      dm_rdata,
    output logic                dm_en,
    output logic                dm_we,
    output cpu_pkg::word_t      dm_addr,
    output cpu_pkg::word_t      dm_wdata,
    output cpu_pkg::word_t      mem_fwd_data,
    output logic                wb_we,
    output cpu_pkg::reg_addr_t  wb_rd,
    output cpu_pkg::word_t      wb_data
);

    // word access only
    assign dm_en    = mem_read || mem_write;
    assign dm_we    = mem_write;
    assign dm_addr  = mem_alu_result;
    assign dm_wdata = mem_store_data;

    // two-way writeback select that also feeds the EX forwarding path
    assign mem_fwd_data = mem_read ? dm_rdata : mem_alu_result;

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_fwd_data;
    end

    assert property (@(posedge clk) disable iff (rst) dm_we |-> dm_en)
        else $error("data memory write without enable");

    // misaligned address means a bad base register or offset upstream
    assert property (@(posedge clk) disable iff (rst) dm_en |-> dm_addr[1:0] == 2'b00)
        else $error("misaligned data memory access");

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    input  logic               we,
    input  cpu_pkg::reg_addr_t rd_addr,
    input  cpu_pkg::word_t     rd_data,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads zero, a same-cycle write passes straight through
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (we && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (we && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_cpu -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sources.f
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
cpu_core.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam logic [31:0] PROG_BASE = 32'h0000_0100;
    localparam int STORE_TIMEOUT = 100;

    logic        clk;
    logic        rst;
    logic [31:0] im_addr;
    logic [31:0] im_data;
    logic [31:0] im_off;
    logic        dm_en;
    logic        dm_we;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;
    logic [31:0] dm_rdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];

    // program table with one slice of the queues per test
    logic [31:0] prog_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    int          prog_first[$];
    int          prog_count[$];
    int          exp_first[$];
    int          exp_count[$];

    cpu_core #(.RESET_PC(PROG_BASE)) i_cpu_core (
        .clk      (clk),
        .rst      (rst),
        .im_data  (im_data),
        .dm_rdata (dm_rdata),
        .im_addr  (im_addr),
        .dm_en    (dm_en),
        .dm_we    (dm_we),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    assign im_off   = im_addr - PROG_BASE;
    assign im_data  = (im_off < 32'd256) ? imem[im_off[7:2]] : enc_addi(0, 0, 0);
    assign dm_rdata = dmem[dm_addr[9:2]];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= '0;
            end
        end else if (dm_en && dm_we) begin
            dmem[dm_addr[9:2]] <= dm_wdata;
        end
    end

    // ----------------------------------------
    // RV32I encoders
    // ----------------------------------------
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lw(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // f3 0 is beq, 1 is bne
    function automatic logic [31:0] enc_br(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    // ----------------------------------------
    // table building
    // ----------------------------------------
    task automatic open_test();
        prog_first.push_back(prog_q.size());
        exp_first.push_back(exp_addr_q.size());
    endtask

    task automatic close_test();
        // every program parks in a self-loop
        prog_q.push_back(enc_br(0, 0, 0, 0));
        prog_count.push_back(prog_q.size() - prog_first[$]);
        exp_count.push_back(exp_addr_q.size() - exp_first[$]);
    endtask

    task automatic add_insn(logic [31:0] w);
        prog_q.push_back(w);
    endtask

    task automatic add_store(logic [31:0] addr, logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // ----------------------------------------
    // checking
    // ----------------------------------------
    task automatic report_fail(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            report_fail("value mismatch");
        end
    endtask

    task automatic reset_and_load(int t);
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] <= (i < prog_count[t]) ? prog_q[prog_first[t] + i] : enc_addi(0, 0, 0);
        end
        repeat (2) begin
            @(negedge clk);
            check_value("dm_en", {31'd0, dm_en}, 32'd0);
            check_value("dm_we", {31'd0, dm_we}, 32'd0);
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_value("im_addr", im_addr, PROG_BASE);
    endtask

    // sampled at the falling edge with one store per MEM cycle
    task automatic wait_store(int t, int k);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (dm_en && dm_we) begin
                seen = 1'b1;
            end else if (k == 0 && (dm_en || dm_we)) begin
                report_fail($sformatf("test %0d: data memory access before the first store", t));
            end
        end
        if (!seen) begin
            report_fail($sformatf("test %0d: store %0d did not arrive within %0d cycles",
                                  t, k, STORE_TIMEOUT));
        end
    endtask

    initial begin
        rst <= 1'b1;

        // arithmetic, both forwarding paths, slt on negatives
        open_test();
        add_insn(enc_addi(1, 0, 5));
        add_insn(enc_addi(2, 0, -3));
        add_insn(enc_r(0, 2, 1, 0, 3));
        add_insn(enc_r(32, 1, 3, 0, 4));
        add_insn(enc_r(0, 1, 4, 7, 5));
        add_insn(enc_r(0, 2, 5, 6, 6));
        add_insn(enc_r(0, 1, 6, 4, 7));
        add_insn(enc_r(0, 1, 2, 2, 8));
        add_insn(enc_r(0, 2, 1, 2, 9));
        add_insn(enc_r(0, 2, 7, 2, 10));
        for (int r = 3; r <= 10; r++) begin
            add_insn(enc_sw(r, 0, 32'h40 + 4 * (r - 3)));
        end
        add_store(32'h40, 32'd2);
        add_store(32'h44, 32'hffff_fffd);
        add_store(32'h48, 32'd5);
        add_store(32'h4c, 32'hffff_fffd);
        add_store(32'h50, 32'hffff_fff8);
        add_store(32'h54, 32'd1);
        add_store(32'h58, 32'd0);
        add_store(32'h5c, 32'd1);
        close_test();

        // store, then load-use with the one-cycle stall
        open_test();
        add_insn(enc_addi(1, 0, 32'h123));
        add_insn(enc_addi(2, 0, 32'h80));
        add_insn(enc_sw(1, 2, 0));
        add_insn(enc_lw(3, 2, 0));
        add_insn(enc_addi(4, 3, 1));
        add_insn(enc_sw(4, 2, 4));
        add_insn(enc_lw(5, 2, 0));
        add_insn(enc_sw(5, 2, 8));
        add_store(32'h80, 32'h123);
        add_store(32'h84, 32'h124);
        add_store(32'h88, 32'h123);
        close_test();

        // taken beq, taken bne, not-taken bne
        open_test();
        add_insn(enc_addi(1, 0, 7));
        add_insn(enc_addi(2, 0, 7));
        add_insn(enc_addi(3, 0, 32'h11));
        add_insn(enc_br(0, 1, 2, 12));
        add_insn(enc_sw(3, 0, 32'h60));
        add_insn(enc_sw(3, 0, 32'h64));
        add_insn(enc_addi(4, 0, 32'h22));
        add_insn(enc_sw(4, 0, 32'h68));
        add_insn(enc_br(1, 1, 4, 12));
        add_insn(enc_sw(3, 0, 32'h6c));
        add_insn(enc_sw(3, 0, 32'h70));
        add_insn(enc_br(1, 1, 2, 8));
        add_insn(enc_addi(5, 0, 32'h33));
        add_insn(enc_sw(5, 0, 32'h74));
        add_store(32'h68, 32'h22);
        add_store(32'h74, 32'h33);
        close_test();

        // writes to x0 are dropped
        open_test();
        add_insn(enc_addi(0, 0, 32'h55));
        add_insn(enc_sw(0, 0, 32'h90));
        add_insn(enc_addi(1, 0, 5));
        add_insn(enc_r(0, 1, 1, 0, 0));
        add_insn(enc_sw(0, 0, 32'h94));
        add_store(32'h90, 32'd0);
        add_store(32'h94, 32'd0);
        close_test();

        for (int t = 0; t < prog_first.size(); t++) begin
            reset_and_load(t);
            for (int k = 0; k < exp_count[t]; k++) begin
                wait_store(t, k);
                check_value("dm_addr", dm_addr, exp_addr_q[exp_first[t] + k]);
                check_value("dm_wdata", dm_wdata, exp_data_q[exp_first[t] + k]);
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
